// File: include/pq_macros.svh
/* Packet queue build constants */

`ifndef PQ_MACROS_SVH
`define PQ_MACROS_SVH

// Number of identical packet lanes
// Must be a power of two so the round-robin pointers wrap on their own
`define PQ_LANES 4

// Longest packet in beats, which is also the word storage of one lane
// A power of two keeps the lane address a plain slice of the count
`define PQ_DEPTH 8

// Width of one data word on ingress, inside the lanes and on egress
`define PQ_DATA_W 32

`endif

// File: hdl/pq_pkg.sv
/* Packet queue types */

`default_nettype none

`include "pq_macros.svh"

package pq_pkg;

  // Selects one lane
  // Used by the write pointer in the dispatcher and the read pointer in the drainer
  typedef logic [$clog2(`PQ_LANES)-1:0] lane_idx_t;

  // Holds a beat count from 0 up to and including PQ_DEPTH
  // One bit wider than a lane address so a full lane is still representable
  typedef logic [$clog2(`PQ_DEPTH):0] beat_cnt_t;

  // Life cycle of one lane
  // FREE takes a new packet, FILLING is part way through a write,
  // READY holds a whole packet, DRAINING is part way through a read
  typedef enum logic [1:0] {
    FREE     = 2'd0,
    FILLING  = 2'd1,
    READY    = 2'd2,
    DRAINING = 2'd3
  } lane_state_e;

endpackage : pq_pkg

`default_nettype wire

// File: hdl/pq_dispatch.sv
/* Ingress packet dispatcher */

`timescale 1ns/10ps
`default_nettype none

`include "pq_macros.svh"

module pq_dispatch (
    input  wire logic                        i_ingress_vld
  , input  wire logic                        i_ingress_sop
  , input  wire logic                        i_ingress_eop
  , input  wire logic [`PQ_DATA_W-1:0]       i_ingress_dat
  , input  wire pq_pkg::lane_state_e         i_lane_state [`PQ_LANES]
  , output logic      [`PQ_LANES-1:0]        o_wr_en
  , output logic      [`PQ_LANES-1:0]        o_wr_first
  , output logic      [`PQ_LANES-1:0]        o_wr_commit
  , output logic      [`PQ_LANES-1:0]        o_wr_abort
  , output logic      [`PQ_DATA_W-1:0]       o_wr_dat
  , output logic                             o_drop_r
  , input  wire logic                        clk
  , input  wire logic                        i_rst_n
);

  // Lane that takes the next accepted packet
  pq_pkg::lane_idx_t wr_ptr_r;
  // Beats already written for the open packet
  pq_pkg::beat_cnt_t cnt_r;
  // The open packet is being kept rather than discarded
  logic              accept_r;
  // A packet has started and its eop has not yet been seen
  logic              in_pkt_r;

  logic              start;
  logic              start_ok;
  logic              cur_acc;
  logic              over;
  logic              wr;

  always_comb begin
    start    = i_ingress_vld && i_ingress_sop;
    // A packet is only kept if its whole lane is free at the sop beat
    start_ok = start && (i_lane_state[wr_ptr_r] == pq_pkg::FREE);
    cur_acc  = start ? start_ok : accept_r;
    // The lane is already full, so this beat pushes the packet past PQ_DEPTH
    over     = i_ingress_vld && !start && accept_r
               && (cnt_r == pq_pkg::beat_cnt_t'(`PQ_DEPTH));
    wr       = i_ingress_vld && cur_acc && !over;
  end

  // Strobes go only to the lane at the write pointer
  always_comb begin
    o_wr_en               = '0;
    o_wr_first            = '0;
    o_wr_commit           = '0;
    o_wr_abort            = '0;
    o_wr_en[wr_ptr_r]     = wr;
    o_wr_first[wr_ptr_r]  = wr && i_ingress_sop;
    o_wr_commit[wr_ptr_r] = wr && i_ingress_eop;
    o_wr_abort[wr_ptr_r]  = over;
  end

  // Write data is broadcast and the enables pick the lane
  assign o_wr_dat = i_ingress_dat;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr_r <= '0;
      cnt_r    <= '0;
      accept_r <= 1'b0;
      in_pkt_r <= 1'b0;
      o_drop_r <= 1'b0;
    end else begin
      // One pulse per dropped packet that is either refused at sop or cut as oversize
      o_drop_r <= (start && !start_ok) || over;
      if (i_ingress_vld) begin
        in_pkt_r <= !i_ingress_eop;
        // After an abort the rest of the packet is swallowed up to its eop
        accept_r <= cur_acc && !over && !i_ingress_eop;
      end
      if (wr) begin
        cnt_r <= start ? pq_pkg::beat_cnt_t'(1) : cnt_r + 1'b1;
      end
      // Only a committed packet moves on, so an aborted lane is reused next
      if (wr && i_ingress_eop) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
    end
  end

  // The source may not open a packet inside an open one
  a_sop_in_pkt : assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_ingress_vld && i_ingress_sop) |-> !in_pkt_r);

endmodule : pq_dispatch

`default_nettype wire

// File: hdl/pq_lane.sv
/* Single packet lane */

`timescale 1ns/10ps
`default_nettype none

`include "pq_macros.svh"

module pq_lane (
    input  wire logic                        i_wr_en
  , input  wire logic                        i_wr_first
  , input  wire logic                        i_wr_commit
  , input  wire logic                        i_wr_abort
  , input  wire logic [`PQ_DATA_W-1:0]       i_wr_dat
  , input  wire logic                        i_rd
  , output pq_pkg::lane_state_e              o_state
  , output logic      [`PQ_DATA_W-1:0]       o_rd_dat
  , output logic                             o_rd_last
  , input  wire logic                        clk
  , input  wire logic                        i_rst_n
);

  localparam int ADDR_W = $clog2(`PQ_DEPTH);

  // Word store for one whole packet
  logic [`PQ_DATA_W-1:0] mem [`PQ_DEPTH];
  // Number of words held, which is the packet length once READY
  pq_pkg::beat_cnt_t     wr_cnt_r;
  // Beats already sent out from this lane
  pq_pkg::beat_cnt_t     rd_ptr_r;
  pq_pkg::lane_state_e   state_r;
  logic [ADDR_W-1:0]     wr_addr;

  // The first beat always lands in word 0 whatever was left from before
  assign wr_addr = i_wr_first ? '0 : wr_cnt_r[ADDR_W-1:0];

  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      mem[wr_addr] <= i_wr_dat;
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_cnt_r <= '0;
      rd_ptr_r <= '0;
      state_r  <= pq_pkg::FREE;
    end else begin
      if (i_wr_en) begin
        wr_cnt_r <= i_wr_first ? pq_pkg::beat_cnt_t'(1) : wr_cnt_r + 1'b1;
      end
      // Rewind on the last read so the next packet starts at word 0
      if (i_rd) begin
        rd_ptr_r <= o_rd_last ? '0 : rd_ptr_r + 1'b1;
      end
      case (state_r)
        pq_pkg::FREE: begin
          // A one-beat packet goes straight to READY
          if (i_wr_en && i_wr_first) begin
            state_r <= i_wr_commit ? pq_pkg::READY : pq_pkg::FILLING;
          end
        end
        pq_pkg::FILLING: begin
          if (i_wr_abort) begin
            state_r <= pq_pkg::FREE;
          end else if (i_wr_en && i_wr_commit) begin
            state_r <= pq_pkg::READY;
          end
        end
        pq_pkg::READY: begin
          if (i_rd) begin
            state_r <= o_rd_last ? pq_pkg::FREE : pq_pkg::DRAINING;
          end
        end
        default: begin
          if (i_rd && o_rd_last) begin
            state_r <= pq_pkg::FREE;
          end
        end
      endcase
    end
  end

  assign o_state   = state_r;
  assign o_rd_dat  = mem[rd_ptr_r[ADDR_W-1:0]];
  // The read pointer has reached the final stored word
  assign o_rd_last = (rd_ptr_r + 1'b1) == wr_cnt_r;

  // Dispatcher only writes or aborts a lane that is free or being filled
  a_wr_state : assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_wr_en || i_wr_abort)
      |-> (state_r == pq_pkg::FREE || state_r == pq_pkg::FILLING));

  // A free lane is always opened by the sop beat of a packet
  a_wr_open : assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_wr_en && state_r == pq_pkg::FREE) |-> i_wr_first);

  // Drainer only reads a lane that holds a complete packet
  a_rd_state : assert property (@(posedge clk) disable iff (!i_rst_n)
    i_rd |-> (state_r == pq_pkg::READY || state_r == pq_pkg::DRAINING));

endmodule : pq_lane

`default_nettype wire

// File: hdl/pq_drain.sv
/* Egress lane drainer */

`timescale 1ns/10ps
`default_nettype none

`include "pq_macros.svh"

module pq_drain (
    input  wire logic                        i_egress_stall
  , input  wire pq_pkg::lane_state_e         i_lane_state [`PQ_LANES]
  , input  wire logic [`PQ_DATA_W-1:0]       i_rd_dat [`PQ_LANES]
  , input  wire logic [`PQ_LANES-1:0]        i_rd_last
  , output logic      [`PQ_LANES-1:0]        o_rd
  , output logic                             o_egress_vld_r
  , output logic                             o_egress_sop_r
  , output logic                             o_egress_eop_r
  , output logic      [`PQ_DATA_W-1:0]       o_egress_dat_r
  , output logic                             o_busy_r
  , input  wire logic                        clk
  , input  wire logic                        i_rst_n
);

  // Follows the dispatcher's lane order, which keeps packets in arrival order
  pq_pkg::lane_idx_t rd_ptr_r;
  // A packet is being read out of the lane at the read pointer
  logic              active_r;
  logic              any_held;
  logic              first;
  logic              last;

  // One read strobe per cycle while a packet is in flight
  always_comb begin
    o_rd           = '0;
    o_rd[rd_ptr_r] = active_r;
  end

  // The lane is still READY only until its first beat is read
  assign first = i_lane_state[rd_ptr_r] == pq_pkg::READY;
  assign last  = i_rd_last[rd_ptr_r];

  always_comb begin
    any_held = 1'b0;
    for (int i = 0; i < `PQ_LANES; i++) begin
      if (i_lane_state[i] != pq_pkg::FREE) begin
        any_held = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_ptr_r       <= '0;
      active_r       <= 1'b0;
      o_egress_vld_r <= 1'b0;
      o_egress_sop_r <= 1'b0;
      o_egress_eop_r <= 1'b0;
      o_egress_dat_r <= '0;
      o_busy_r       <= 1'b0;
    end else begin
      o_egress_vld_r <= active_r;
      o_egress_sop_r <= active_r && first;
      o_egress_eop_r <= active_r && last;
      o_busy_r       <= any_held;
      if (active_r) begin
        o_egress_dat_r <= i_rd_dat[rd_ptr_r];
      end
      if (!active_r) begin
        // Stall is only looked at here, between packets
        if (first && !i_egress_stall) begin
          active_r <= 1'b1;
        end
      end else if (last) begin
        active_r <= 1'b0;
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
    end
  end

  // A packet leaves as an unbroken run of beats from sop to eop
  a_egress_run : assert property (@(posedge clk) disable iff (!i_rst_n)
    (o_egress_vld_r && !o_egress_eop_r) |=> (o_egress_vld_r && !o_egress_sop_r));

endmodule : pq_drain

`default_nettype wire

// File: hdl/q.sv
/* Store-and-forward packet queue */

`timescale 1ns/10ps
`default_nettype none

`include "pq_macros.svh"

module q (
    input  wire logic                        i_ingress_vld
  , input  wire logic                        i_ingress_sop
  , input  wire logic                        i_ingress_eop
  , input  wire logic [`PQ_DATA_W-1:0]       i_ingress_dat
  , input  wire logic                        i_egress_stall
  , output wire logic                        o_egress_vld_r
  , output wire logic                        o_egress_sop_r
  , output wire logic                        o_egress_eop_r
  , output wire logic [`PQ_DATA_W-1:0]       o_egress_dat_r
  , output wire logic                        o_drop_r
  , output wire logic                        o_busy_r
  , input  wire logic                        clk
  , input  wire logic                        i_rst_n
);

  // Write side strobes, one bit per lane
  logic [`PQ_LANES-1:0]  wr_en;
  logic [`PQ_LANES-1:0]  wr_first;
  logic [`PQ_LANES-1:0]  wr_commit;
  logic [`PQ_LANES-1:0]  wr_abort;
  logic [`PQ_DATA_W-1:0] wr_dat;

  // Lane status seen by both the dispatcher and the drainer
  pq_pkg::lane_state_e   lane_state [`PQ_LANES];

  // Read side
  logic [`PQ_LANES-1:0]  rd;
  logic [`PQ_DATA_W-1:0] rd_dat [`PQ_LANES];
  logic [`PQ_LANES-1:0]  rd_last;

  pq_dispatch u_dispatch (
      .i_ingress_vld  (i_ingress_vld)
    , .i_ingress_sop  (i_ingress_sop)
    , .i_ingress_eop  (i_ingress_eop)
    , .i_ingress_dat  (i_ingress_dat)
    , .i_lane_state   (lane_state)
    , .o_wr_en        (wr_en)
    , .o_wr_first     (wr_first)
    , .o_wr_commit    (wr_commit)
    , .o_wr_abort     (wr_abort)
    , .o_wr_dat       (wr_dat)
    , .o_drop_r       (o_drop_r)
    , .clk            (clk)
    , .i_rst_n        (i_rst_n)
  );

  for (genvar g = 0; g < `PQ_LANES; g++) begin : g_lane
    pq_lane u_lane (
        .i_wr_en      (wr_en[g])
      , .i_wr_first   (wr_first[g])
      , .i_wr_commit  (wr_commit[g])
      , .i_wr_abort   (wr_abort[g])
      , .i_wr_dat     (wr_dat)
      , .i_rd         (rd[g])
      , .o_state      (lane_state[g])
      , .o_rd_dat     (rd_dat[g])
      , .o_rd_last    (rd_last[g])
      , .clk          (clk)
      , .i_rst_n      (i_rst_n)
    );
  end

  pq_drain u_drain (
      .i_egress_stall (i_egress_stall)
    , .i_lane_state   (lane_state)
    , .i_rd_dat       (rd_dat)
    , .i_rd_last      (rd_last)
    , .o_rd           (rd)
    , .o_egress_vld_r (o_egress_vld_r)
    , .o_egress_sop_r (o_egress_sop_r)
    , .o_egress_eop_r (o_egress_eop_r)
    , .o_egress_dat_r (o_egress_dat_r)
    , .o_busy_r       (o_busy_r)
    , .clk            (clk)
    , .i_rst_n        (i_rst_n)
  );

endmodule : q

`default_nettype wire

// File: verif/tb.sv
/* Packet queue testbench */

`timescale 1ns/10ps
`default_nettype none

`include "pq_macros.svh"

module tb;

  localparam int TIMEOUT_CYCLES = 4000;

  logic                  clk;
  logic                  i_rst_n;
  logic                  i_ingress_vld;
  logic                  i_ingress_sop;
  logic                  i_ingress_eop;
  logic [`PQ_DATA_W-1:0] i_ingress_dat;
  logic                  i_egress_stall;
  logic                  o_egress_vld_r;
  logic                  o_egress_sop_r;
  logic                  o_egress_eop_r;
  logic [`PQ_DATA_W-1:0] o_egress_dat_r;
  logic                  o_drop_r;
  logic                  o_busy_r;

  // Expected egress beats as {sop, eop, data}, and the beats of the open packet
  logic [`PQ_DATA_W+1:0] exp_q [$];
  logic [`PQ_DATA_W+1:0] pend_q [$];
  // Packets committed to a lane and not yet seen leaving on egress
  int                    held = 0;
  int                    nbeat = 0;
  int                    drop_cnt = 0;
  int                    cycle_cnt = 0;
  logic                  acc = 1'b0;

  // Model state sampled by the assertions one edge behind the model
  int                    held_r = 0;
  logic                  exp_drop_r = 1'b0;
  logic                  head_ok_r = 1'b0;
  logic                  head_sop_r = 1'b0;
  logic                  head_eop_r = 1'b0;
  logic [`PQ_DATA_W-1:0] head_dat_r = '0;
  // Held count two edges behind, and a packet seen to finish one edge behind
  int                    held_rr = 0;
  logic                  done_r = 1'b0;

  q dut (
      .i_ingress_vld  (i_ingress_vld)
    , .i_ingress_sop  (i_ingress_sop)
    , .i_ingress_eop  (i_ingress_eop)
    , .i_ingress_dat  (i_ingress_dat)
    , .i_egress_stall (i_egress_stall)
    , .o_egress_vld_r (o_egress_vld_r)
    , .o_egress_sop_r (o_egress_sop_r)
    , .o_egress_eop_r (o_egress_eop_r)
    , .o_egress_dat_r (o_egress_dat_r)
    , .o_drop_r       (o_drop_r)
    , .o_busy_r       (o_busy_r)
    , .clk            (clk)
    , .i_rst_n        (i_rst_n)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "run stopped on the first failure");
  endtask

  // Reference model
  // Lanes fill and drain in one shared round-robin order, so the lane at the
  // write pointer is free exactly when fewer than PQ_LANES packets are held
  always @(posedge clk) begin : ref_model
    logic drop_now;
    logic done_now;
    drop_now = 1'b0;
    done_now = 1'b0;
    if (i_rst_n) begin
      if (o_drop_r) drop_cnt++;
      if (o_egress_vld_r && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
      if (o_egress_vld_r && o_egress_eop_r && held != 0) begin
        held--;
        done_now = 1'b1;
      end
      if (i_ingress_vld) begin
        if (i_ingress_sop) begin
          acc      = held < `PQ_LANES;
          nbeat    = 0;
          drop_now = !acc;
          pend_q.delete();
        end else if (acc && nbeat == `PQ_DEPTH) begin
          // Beat past the lane size cuts the whole packet
          acc      = 1'b0;
          drop_now = 1'b1;
        end
        if (acc) begin
          pend_q.push_back({i_ingress_sop, i_ingress_eop, i_ingress_dat});
          nbeat++;
          if (i_ingress_eop) begin
            foreach (pend_q[i]) exp_q.push_back(pend_q[i]);
            held++;
            acc = 1'b0;
          end
        end
      end
    end
    exp_drop_r <= drop_now;
    held_r     <= held;
    held_rr    <= held_r;
    done_r     <= done_now;
    head_ok_r  <= exp_q.size() != 0;
    if (exp_q.size() != 0) begin
      {head_sop_r, head_eop_r, head_dat_r} <= exp_q[0];
    end
  end

  // Every egress beat is the oldest expected beat, flags included
  a_egress_beat : assert property (@(posedge clk) disable iff (!i_rst_n)
    o_egress_vld_r |-> (head_ok_r && o_egress_dat_r == head_dat_r
      && o_egress_sop_r == head_sop_r && o_egress_eop_r == head_eop_r))
    else fail_run($sformatf("[ERROR] %0t egress beat dat=%h sop=%b eop=%b, expected %h %b %b",
      $time, o_egress_dat_r, o_egress_sop_r, o_egress_eop_r, head_dat_r, head_sop_r,
      head_eop_r));

  a_drop : assert property (@(posedge clk) disable iff (!i_rst_n) o_drop_r == exp_drop_r)
    else fail_run($sformatf("[ERROR] %0t o_drop_r is %b, expected %b", $time, o_drop_r,
      exp_drop_r));

  // Busy lags the lane states by one edge and the model sees a freed lane only on egress
  a_busy : assert property (@(posedge clk) disable iff (!i_rst_n)
    ((held_rr - int'(done_r)) != 0) |-> o_busy_r)
    else fail_run($sformatf("[ERROR] %0t o_busy_r low while %0d packets held", $time,
      held_rr - int'(done_r)));

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      fail_run($sformatf("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  task automatic send_packet(input int len, input int gap);
    for (int b = 0; b < len; b++) begin
      @(posedge clk);
      i_ingress_vld <= 1'b1;
      i_ingress_sop <= (b == 0);
      i_ingress_eop <= (b == len - 1);
      i_ingress_dat <= $urandom;
    end
    repeat (gap) begin
      @(posedge clk);
      i_ingress_vld <= 1'b0;
      i_ingress_sop <= 1'b0;
      i_ingress_eop <= 1'b0;
    end
  endtask

  // Waits until the model has seen every kept packet leave
  task automatic wait_drain();
    while (held != 0 || exp_q.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
  endtask

  initial begin
    int drops_before;
    void'($urandom(32'h7cf2b918));
    i_rst_n        = 1'b0;
    i_ingress_vld  = 1'b0;
    i_ingress_sop  = 1'b0;
    i_ingress_eop  = 1'b0;
    i_ingress_dat  = '0;
    i_egress_stall = 1'b0;
    repeat (15) @(posedge clk);
    @(negedge clk);
    assert (!o_egress_vld_r && !o_egress_sop_r && !o_egress_eop_r && o_egress_dat_r == '0
            && !o_drop_r && !o_busy_r)
      else fail_run($sformatf("[ERROR] %0t outputs not low in reset", $time));
    @(posedge clk);
    i_rst_n <= 1'b1;

    // Random packets with gaps of at least two cycles so the drainer keeps pace
    drops_before = drop_cnt;
    for (int p = 0; p < 40; p++) begin
      send_packet($urandom_range(1, `PQ_DEPTH), $urandom_range(2, 5));
    end
    wait_drain();
    assert (drop_cnt == drops_before)
      else fail_run($sformatf("[ERROR] %0t unexpected drop in the random run", $time));

    // One-beat packets sent back to back with short gaps
    for (int p = 0; p < 6; p++) send_packet(1, 2);
    wait_drain();

    // Stall egress and fill every lane, then one more packet is dropped
    @(posedge clk);
    i_egress_stall <= 1'b1;
    drops_before = drop_cnt;
    for (int p = 0; p <= `PQ_LANES; p++) begin
      send_packet($urandom_range(1, `PQ_DEPTH), 1);
    end
    repeat (3) @(negedge clk);
    assert (drop_cnt == drops_before + 1 && held == `PQ_LANES)
      else fail_run($sformatf("[ERROR] %0t full lanes gave %0d drops with %0d held", $time,
        drop_cnt - drops_before, held));
    @(posedge clk);
    i_egress_stall <= 1'b0;
    wait_drain();

    // Oversize packet is cut and the packets after it still flow
    drops_before = drop_cnt;
    send_packet(`PQ_DEPTH + 1, 2);
    for (int p = 0; p < 3; p++) send_packet($urandom_range(1, `PQ_DEPTH), 2);
    wait_drain();
    assert (drop_cnt == drops_before + 1)
      else fail_run($sformatf("[ERROR] %0t oversize packet gave %0d drops", $time,
        drop_cnt - drops_before));

    // Queue is idle, so busy and egress must have fallen
    if (held == 0 && exp_q.size() == 0 && !o_busy_r && !o_egress_vld_r) begin
      $display("All tests passed!");
      $finish;
    end else begin
      fail_run($sformatf("[ERROR] %0t queue not idle at the end, busy=%b", $time, o_busy_r));
    end
  end

endmodule : tb

`default_nettype wire

// File: project.f
+incdir+include
hdl/pq_pkg.sv
hdl/pq_dispatch.sv
hdl/pq_lane.sv
hdl/pq_drain.sv
hdl/q.sv
verif/tb.sv

// File: run.sh
#!/bin/sh
# Builds the packet queue testbench with Verilator, runs it and checks the log
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb \
  --Mdir obj_dir -f project.f > "$LOG" 2>&1 \
  && ./obj_dir/Vtb >> "$LOG" 2>&1 \
  || echo "Build or simulation ended with an error status" >> "$LOG"

cat "$LOG"
if grep -q "Test failures found" "$LOG"; then exit 1; fi
grep -q "All tests passed!" "$LOG" || exit 1
exit 0
